//--- zx_pager_testdata.txt
# columns: op addr data expected, all hex; W port write, P port read, M mem read, N mem write, I idle
# expected for M and N: bits 31:28 kind (0 ram_addr, 1 rom_page, 2 no select); for P: d_out
# reset map
M 0000 00 10000000
M 1234 00 10000000
M 4000 00 00014000
M 5abc 00 00015abc
M 8000 00 00008000
M 9fff 00 00009fff
M c000 00 00000000
M ffff 00 00003fff
P 00be 00 00000080
P 40be 00 00000005
P 80be 00 00000002
P c0be 00 00000000
I 0000 00 00000000
# pager writes to each window
W 00f7 83 00000000
M 0100 00 10000003
P 00be 00 00000083
W 40f7 11 00000000
M 4010 00 00044010
P 40be 00 00000011
W 80f7 9e 00000000
M 8000 00 1000001e
P 80be 00 0000009e
W c0f7 2a 00000000
M c123 00 000a0123
P c0be 00 0000002a
W 00f7 ff 00000000
M 0000 00 1000001f
P 00be 00 000000ff
W 00f7 7f 00000000
M 3fff 00 001fffff
P 00be 00 0000007f
# 7ffd low bits go to window 3 only
W 7ffd 07 00000000
M c000 00 000bc000
M 4010 00 00044010
M 8000 00 1000001e
M 0000 00 001fc000
P c0be 00 0000002a
W 7ffd 03 00000000
M c004 00 000ac004
W c0f7 85 00000000
M c000 00 10000005
N c000 5a 20000000
P c0be 00 00000085
W c0f7 10 00000000
# memory writes
N c055 aa 0004c055
N 8000 00 20000000
N 4fff 3c 00044fff
I 0000 00 00000000
# lock through 7ffd bit 5
W 7ffd 21 00000000
M c000 00 00044000
W 7ffd 06 00000000
M c000 00 00044000
W 40f7 33 00000000
M 4000 00 00044000
P 40be 00 00000011
W 00f7 81 00000000
M 0000 00 001fc000
P 00be 00 0000007f
W 80f7 01 00000000
M 8abc 00 1000001e
P 80be 00 0000009e
P c0be 00 00000010
N 4123 77 00044123
I 0000 00 00000000

//--- zx_pager.f
+incdir+.
zx_bus_pkg.sv
zx_map_pkg.sv
zbus_sampler.sv
window_pager.sv
mem_mapper.sv
zx_pager_top.sv
zx_pager_assert.sv
tb_zx_pager.sv

//--- tb_zx_pager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_pager;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES = 6;

	logic                  fclk;
	logic                  rst_n;
	logic                  iorq_n;
	logic                  mreq_n;
	logic                  rd_n;
	logic                  wr_n;
	zx_bus_pkg::zaddr_t    a;
	zx_bus_pkg::zdata_t    d_in;
	zx_map_pkg::ram_addr_t ram_addr;
	logic                  ram_cs_n;
	logic                  rom_cs_n;
	zx_map_pkg::rompg_t    rom_page;
	zx_bus_pkg::zdata_t    d_out;
	logic                  d_oe;

	// one entry per operation of the data file
	logic [7:0]  op_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	logic [31:0] exp_q[$];

	int errors;
	int checks;
	int total;
	bit loaded;

	zx_pager_top u_dut (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.a        (a),
		.d_in     (d_in),
		.ram_addr (ram_addr),
		.ram_cs_n (ram_cs_n),
		.rom_cs_n (rom_cs_n),
		.rom_page (rom_page),
		.d_out    (d_out),
		.d_oe     (d_oe)
	);

	bind zx_pager_top zx_pager_assert u_assert (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.a        (a),
		.ram_addr (ram_addr),
		.ram_cs_n (ram_cs_n),
		.rom_cs_n (rom_cs_n),
		.d_oe     (d_oe)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	// watchdog at twice the nominal run length
	initial
	begin
		longint timeout_ns;
		wait (loaded);
		timeout_ns = 2 * (op_q.size() + 1) * HOLD_CYCLES * CLK_PERIOD
			+ RESET_CYCLES * CLK_PERIOD;
		#(timeout_ns);
		$display("timeout after %0d ns, the run did not reach its end", timeout_ns);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic read_testdata();
		int          fd;
		int          code;
		int          c;
		bit          done;
		logic [7:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] exp_val;
		fd = $fopen("zx_pager_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open zx_pager_testdata.txt");
			errors++;
			return;
		end
		done = 0;
		while (!done)
		begin
			code = $fscanf(fd, " %c", op);
			if (code != 1)
			begin
				done = 1;
			end
			else if (op == "#")
			begin
				// comment runs to end of line
				c = $fgetc(fd);
				while (c != "\n" && c != -1)
				begin
					c = $fgetc(fd);
				end
			end
			else
			begin
				code = $fscanf(fd, "%h %h %h", addr, data, exp_val);
				if (code != 3)
				begin
					$display("malformed line after operation %0d in test data", op_q.size());
					errors++;
					done = 1;
				end
				else
				begin
					op_q.push_back(op);
					addr_q.push_back(addr);
					data_q.push_back(data);
					exp_q.push_back(exp_val);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic set_bus(input logic iorq_v, input logic mreq_v, input logic rd_v,
		input logic wr_v, input logic [15:0] addr_v, input logic [7:0] data_v);
		iorq_n = iorq_v;
		mreq_n = mreq_v;
		rd_n = rd_v;
		wr_n = wr_v;
		a = addr_v;
		d_in = data_v;
	endtask

	task automatic check_value(input int idx, input string name, input logic [31:0] got,
		input logic [31:0] exp_val);
		checks++;
		if (got !== exp_val)
		begin
			errors++;
			$display("[ERROR] op %0d (%c %h): %s = 0x%0h, expected 0x%0h",
				idx, op_q[idx], addr_q[idx], name, got, exp_val);
		end
	endtask

	task automatic check_idle(input int idx);
		check_value(idx, "ram_cs_n", ram_cs_n, 32'd1);
		check_value(idx, "rom_cs_n", rom_cs_n, 32'd1);
		check_value(idx, "d_oe", d_oe, 32'd0);
	endtask

	// kind in bits 31:28 of the expected value
	task automatic check_memory(input int idx, input logic [31:0] exp_val);
		case (exp_val[31:28])
			4'h0:
			begin
				check_value(idx, "ram_cs_n", ram_cs_n, 32'd0);
				check_value(idx, "rom_cs_n", rom_cs_n, 32'd1);
				check_value(idx, "ram_addr", ram_addr, exp_val[20:0]);
				check_value(idx, "d_oe", d_oe, 32'd0);
			end
			4'h1:
			begin
				check_value(idx, "ram_cs_n", ram_cs_n, 32'd1);
				check_value(idx, "rom_cs_n", rom_cs_n, 32'd0);
				check_value(idx, "rom_page", rom_page, exp_val[4:0]);
				check_value(idx, "d_oe", d_oe, 32'd0);
			end
			4'h2:
				check_idle(idx);
			default:
			begin
				errors++;
				$display("op %0d has an unknown expected kind %0h", idx, exp_val[31:28]);
			end
		endcase
	endtask

	task automatic run_op(input int idx);
		logic [7:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] exp_val;
		op = op_q[idx];
		addr = addr_q[idx];
		data = data_q[idx];
		exp_val = exp_q[idx];
		case (op)
			"W":
			begin
				set_bus(1'b0, 1'b1, 1'b1, 1'b0, addr, data);
				// strobes drop for the last cycle so a following write gets its own edge
				repeat (HOLD_CYCLES - 1) @(negedge fclk);
				set_bus(1'b1, 1'b1, 1'b1, 1'b1, addr, data);
				@(negedge fclk);
				// outputs still show the write cycle here
				check_idle(idx);
			end
			"P":
			begin
				set_bus(1'b0, 1'b1, 1'b0, 1'b1, addr, data);
				repeat (HOLD_CYCLES) @(negedge fclk);
				check_value(idx, "ram_cs_n", ram_cs_n, 32'd1);
				check_value(idx, "rom_cs_n", rom_cs_n, 32'd1);
				check_value(idx, "d_oe", d_oe, 32'd1);
				check_value(idx, "d_out", d_out, exp_val[7:0]);
			end
			"M":
			begin
				set_bus(1'b1, 1'b0, 1'b0, 1'b1, addr, data);
				repeat (HOLD_CYCLES) @(negedge fclk);
				check_memory(idx, exp_val);
			end
			"N":
			begin
				set_bus(1'b1, 1'b0, 1'b1, 1'b0, addr, data);
				repeat (HOLD_CYCLES) @(negedge fclk);
				check_memory(idx, exp_val);
			end
			"I":
			begin
				set_bus(1'b1, 1'b1, 1'b1, 1'b1, addr, data);
				repeat (HOLD_CYCLES) @(negedge fclk);
				check_idle(idx);
			end
			default:
			begin
				errors++;
				$display("op %0d has an unknown operation code %c", idx, op);
			end
		endcase
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		errors = 0;
		checks = 0;
		loaded = 0;
		rst_n = 1'b0;
		set_bus(1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 8'h00);
		read_testdata();
		if (op_q.size() == 0)
		begin
			errors++;
			$display("no operations found in the test data");
		end
		loaded = 1;
		repeat (RESET_CYCLES) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
		for (int i = 0; i < op_q.size(); i++)
		begin
			run_op(i);
		end
		total = errors + u_dut.u_assert.fail_cnt;
		$display("checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, u_dut.u_assert.fail_cnt);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- zx_pager_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_pager_config.svh"

module zx_pager_assert (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  zx_bus_pkg::zaddr_t    a,
	input  zx_map_pkg::ram_addr_t ram_addr,
	input  logic                  ram_cs_n,
	input  logic                  rom_cs_n,
	input  logic                  d_oe
);

	int   fail_cnt = 0;
	logic rb_read;

	// readback read as seen on the pins
	assign rb_read = ~iorq_n & ~rd_n & (a[7:0] == `ZX_READBACK_PORT_LO);

	//////////////////////////////
	// output properties
	//////////////////////////////

	// ram and rom never share a cycle
	a_one_select: assert property (@(posedge fclk) disable iff (!rst_n)
		!(!ram_cs_n && !rom_cs_n))
	else
	begin
		fail_cnt++;
		$error("ram_cs_n and rom_cs_n both low");
	end

	// two stages between the pins and d_oe
	a_oe_source: assert property (@(posedge fclk) disable iff (!rst_n)
		d_oe |-> $past(rb_read, 2))
	else
	begin
		fail_cnt++;
		$error("d_oe high without a readback read");
	end

	a_reset_idle: assert property (@(posedge fclk)
		$rose(rst_n) |-> (ram_cs_n && rom_cs_n && !d_oe))
	else
	begin
		fail_cnt++;
		$error("outputs not idle when reset is released");
	end

	a_addr_known: assert property (@(posedge fclk) disable iff (!rst_n)
		!ram_cs_n |-> !$isunknown(ram_addr))
	else
	begin
		fail_cnt++;
		$error("ram_addr has unknown bits while selected");
	end

endmodule

`default_nettype wire

//--- zx_pager_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_pager_top (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic                  iorq_n,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  zx_bus_pkg::zaddr_t    a,
	input  zx_bus_pkg::zdata_t    d_in,
	output zx_map_pkg::ram_addr_t ram_addr,
	output logic                  ram_cs_n,
	output logic                  rom_cs_n,
	output zx_map_pkg::rompg_t    rom_page,
	output zx_bus_pkg::zdata_t    d_out,
	output logic                  d_oe
);

	zx_bus_pkg::port_wr_t     port_wr;
	zx_map_pkg::mem_cyc_t     mem_cyc;
	logic                     rd_req;
	zx_bus_pkg::win_idx_t     rd_win;
	zx_map_pkg::win_cfg_set_t win_cfg;
	logic [2:0]               ram3_lo;

	//////////////////////////////
	// bus front end
	//////////////////////////////

	zbus_sampler u_sampler (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.a       (a),
		.d_in    (d_in),
		.port_wr (port_wr),
		.mem_cyc (mem_cyc),
		.rd_req  (rd_req),
		.rd_win  (rd_win)
	);

	//////////////////////////////
	// paging registers
	//////////////////////////////

	window_pager u_pager (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.port_wr (port_wr),
		.win_cfg (win_cfg),
		.ram3_lo (ram3_lo)
	);

	//////////////////////////////
	// address translation
	//////////////////////////////

	mem_mapper u_mapper (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.mem_cyc  (mem_cyc),
		.rd_req   (rd_req),
		.rd_win   (rd_win),
		.win_cfg  (win_cfg),
		.ram3_lo  (ram3_lo),
		.ram_addr (ram_addr),
		.ram_cs_n (ram_cs_n),
		.rom_cs_n (rom_cs_n),
		.rom_page (rom_page),
		.d_out    (d_out),
		.d_oe     (d_oe)
	);

endmodule

`default_nettype wire

//--- mem_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_pager_config.svh"

module mem_mapper (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  zx_map_pkg::mem_cyc_t     mem_cyc,
	input  logic                     rd_req,
	input  zx_bus_pkg::win_idx_t     rd_win,
	input  zx_map_pkg::win_cfg_set_t win_cfg,
	input  logic [2:0]               ram3_lo,
	output zx_map_pkg::ram_addr_t    ram_addr,
	output logic                     ram_cs_n,
	output logic                     rom_cs_n,
	output zx_map_pkg::rompg_t       rom_page,
	output zx_bus_pkg::zdata_t       d_out,
	output logic                     d_oe
);

	localparam zx_bus_pkg::win_idx_t TOP_WIN = zx_bus_pkg::win_idx_t'(`ZX_NUM_WINDOWS - 1);

	zx_map_pkg::win_cfg_t sel_cfg;
	zx_map_pkg::page_t    eff_page;
	logic                 ram_hit;
	logic                 rom_hit;

	//////////////////////////////
	// translation
	//////////////////////////////

	always_comb
	begin
		sel_cfg = win_cfg[mem_cyc.win];
		eff_page = sel_cfg.page;
		// top window takes its low bank bits from 7ffd
		if (mem_cyc.win == TOP_WIN)
		begin
			eff_page[2:0] = ram3_lo;
		end
	end

	assign ram_hit = mem_cyc.valid & ~sel_cfg.rom;

	// rom is read only, writes just vanish
	assign rom_hit = mem_cyc.valid & sel_cfg.rom & ~mem_cyc.write;

	//////////////////////////////
	// memory selects
	//////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ram_cs_n <= 1'b1;
			rom_cs_n <= 1'b1;
			ram_addr <= '0;
			rom_page <= '0;
		end
		else
		begin
			ram_cs_n <= ~ram_hit;
			rom_cs_n <= ~rom_hit;
			if (ram_hit)
			begin
				ram_addr <= {eff_page, mem_cyc.offset};
			end
			// raw window page, the 7ffd bits apply to ram only
			if (rom_hit)
			begin
				rom_page <= sel_cfg.page[`ZX_ROMPG_BITS-1:0];
			end
		end
	end

	//////////////////////////////
	// readback port
	//////////////////////////////

	// stored byte, not the effective page
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			d_oe <= 1'b0;
			d_out <= '0;
		end
		else
		begin
			d_oe <= rd_req;
			if (rd_req)
			begin
				d_out <= zx_bus_pkg::zdata_t'(win_cfg[rd_win]);
			end
		end
	end

endmodule

`default_nettype wire

//--- window_pager.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_pager_config.svh"

module window_pager (
	input  logic                     fclk,
	input  logic                     rst_n,
	input  zx_bus_pkg::port_wr_t     port_wr,
	output zx_map_pkg::win_cfg_set_t win_cfg,
	output logic [2:0]               ram3_lo
);

	//////////////////////////////
	// reset mapping
	//////////////////////////////

	// rom 0 at 0000, then ram 5, ram 2, ram 0 like a plain 128k machine
	localparam zx_map_pkg::win_cfg_t CFG_WIN0 = '{rom: 1'b1, page: 7'd0};
	localparam zx_map_pkg::win_cfg_t CFG_WIN1 = '{rom: 1'b0, page: 7'd5};
	localparam zx_map_pkg::win_cfg_t CFG_WIN2 = '{rom: 1'b0, page: 7'd2};
	localparam zx_map_pkg::win_cfg_t CFG_WIN3 = '{rom: 1'b0, page: 7'd0};

	localparam zx_map_pkg::win_cfg_set_t RESET_MAP = {CFG_WIN3, CFG_WIN2, CFG_WIN1, CFG_WIN0};

	zx_map_pkg::win_cfg_set_t cfg_q;
	zx_bus_pkg::zdata_t       p7ffd_q;
	logic                     locked;
	logic                     wr_7ffd;
	logic                     wr_pager;

	// lock lives inside 7ffd itself
	// once set nothing can write 7ffd again, so it sticks until reset
	assign locked = p7ffd_q[`ZX_LOCK_BIT];

	assign wr_7ffd = port_wr.valid & port_wr.hit_7ffd & ~locked;
	assign wr_pager = port_wr.valid & port_wr.hit_pager & ~locked;

	//////////////////////////////
	// window registers
	//////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg_q <= RESET_MAP;
		end
		else if (wr_pager)
		begin
			// bit 7 rom, bits 6:0 page
			cfg_q[port_wr.win] <= zx_map_pkg::win_cfg_t'(port_wr.data);
		end
	end

	//////////////////////////////
	// port 7ffd
	//////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= '0;
		end
		else if (wr_7ffd)
		begin
			p7ffd_q <= port_wr.data;
		end
	end

	assign win_cfg = cfg_q;

	// 128k bank select, only window 3 uses it
	assign ram3_lo = p7ffd_q[2:0];

endmodule

`default_nettype wire

//--- zbus_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "zx_pager_config.svh"

module zbus_sampler (
	input  logic                   fclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  zx_bus_pkg::zaddr_t     a,
	input  zx_bus_pkg::zdata_t     d_in,
	output zx_bus_pkg::port_wr_t   port_wr,
	output zx_map_pkg::mem_cyc_t   mem_cyc,
	output logic                   rd_req,
	output zx_bus_pkg::win_idx_t   rd_win
);

	zx_bus_pkg::bus_sample_t smp;
	logic                    io_wr;
	logic                    io_rd;
	logic                    io_wr_prev;

	//////////////////////////////
	// bus capture
	//////////////////////////////

	// one snapshot per fclk, strobes flipped to active high
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			smp <= '0;
			io_wr_prev <= 1'b0;
		end
		else
		begin
			smp.a <= a;
			smp.d <= d_in;
			smp.iorq <= ~iorq_n;
			smp.mreq <= ~mreq_n;
			smp.rd <= ~rd_n;
			smp.wr <= ~wr_n;
			io_wr_prev <= io_wr;
		end
	end

	assign io_wr = smp.iorq & smp.wr;
	assign io_rd = smp.iorq & smp.rd;

	//////////////////////////////
	// decode
	//////////////////////////////

	// port write fires once, on its first sampled cycle
	always_comb
	begin
		port_wr.valid = io_wr & ~io_wr_prev;
		port_wr.hit_7ffd = (smp.a == `ZX_PORT_7FFD);
		port_wr.hit_pager = (smp.a[7:0] == `ZX_PAGER_PORT_LO);
		port_wr.win = smp.a[15:`ZX_WINDOW_BITS];
		port_wr.data = smp.d;
	end

	// readback is a level, held while the strobes stay low
	assign rd_req = io_rd & (smp.a[7:0] == `ZX_READBACK_PORT_LO);
	assign rd_win = smp.a[15:`ZX_WINDOW_BITS];

	// refresh has mreq without rd or wr and is ignored
	always_comb
	begin
		mem_cyc.valid = smp.mreq & (smp.rd | smp.wr);
		mem_cyc.write = smp.wr;
		mem_cyc.win = smp.a[15:`ZX_WINDOW_BITS];
		mem_cyc.offset = smp.a[`ZX_WINDOW_BITS-1:0];
	end

endmodule

`default_nettype wire

//--- zx_map_pkg.sv
`default_nettype none

`include "zx_pager_config.svh"

package zx_map_pkg;

	//////////////////////////////
	// page and address widths
	//////////////////////////////

	typedef logic [`ZX_PAGE_BITS-1:0] page_t;

	typedef logic [`ZX_ROMPG_BITS-1:0] rompg_t;

	// page number above the window offset
	typedef logic [`ZX_PAGE_BITS+`ZX_WINDOW_BITS-1:0] ram_addr_t;

	//////////////////////////////
	// window configuration
	//////////////////////////////

	// same layout as the byte written to the pager port
	typedef struct packed {
		logic  rom;
		page_t page;
	} win_cfg_t;

	// index 0 is the window at 0000
	typedef win_cfg_t [`ZX_NUM_WINDOWS-1:0] win_cfg_set_t;

	// memory access seen on the bus, split into window and offset
	typedef struct packed {
		logic                     valid;
		logic                     write;
		zx_bus_pkg::win_idx_t     win;
		logic [`ZX_WINDOW_BITS-1:0] offset;
	} mem_cyc_t;

endpackage

`default_nettype wire

//--- zx_bus_pkg.sv
`default_nettype none

`include "zx_pager_config.svh"

package zx_bus_pkg;

	//////////////////////////////
	// plain z80 bus quantities
	//////////////////////////////

	// 16-bit cpu address
	typedef logic [15:0] zaddr_t;

	// data byte
	typedef logic [7:0] zdata_t;

	// window number, taken from a[15:14]
	typedef logic [$clog2(`ZX_NUM_WINDOWS)-1:0] win_idx_t;

	//////////////////////////////
	// registered bus snapshot
	//////////////////////////////

	// strobes are active high here
	typedef struct packed {
		zaddr_t a;
		zdata_t d;
		logic   iorq;
		logic   mreq;
		logic   rd;
		logic   wr;
	} bus_sample_t;

	// one decoded port write, valid for a single fclk
	typedef struct packed {
		logic     valid;
		logic     hit_7ffd;
		logic     hit_pager;
		win_idx_t win;
		zdata_t   data;
	} port_wr_t;

endpackage

`default_nettype wire

//--- zx_pager_config.svh
`ifndef ZX_PAGER_CONFIG_SVH
`define ZX_PAGER_CONFIG_SVH

// low address byte of the window pager ports, window in a[15:14]
`define ZX_PAGER_PORT_LO 8'hF7

// low address byte of the readback port, window in a[15:14]
`define ZX_READBACK_PORT_LO 8'hBE

// classic 128k paging port, fully decoded
`define ZX_PORT_7FFD 16'h7FFD

// z80 address map
`define ZX_NUM_WINDOWS 4
`define ZX_WINDOW_BITS 14
`define ZX_PAGE_BITS 7
`define ZX_ROMPG_BITS 5

// 7ffd bit that freezes all paging
`define ZX_LOCK_BIT 5

`endif
